// ==== tb.f ====
+incdir+include
hw/spi_bridge_pkg.sv
hw/spi_byte_shifter.sv
hw/spi_cmd_fsm.sv
hw/ctrl_status_regs.sv
hw/word_store.sv
hw/spi_mem_bridge.sv
testbench/tb_clk_gen.sv
testbench/tb_spi_mem_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_spi_mem_bridge -f tb.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi

// ==== testbench/tb_spi_mem_bridge.sv ====
`timescale 1ns/1ps
`include "spi_bridge_defs.svh"

module tb_spi_mem_bridge
   import spi_bridge_pkg::*;
();

   localparam int XFER_BYTES  = 12;   // Command, ten sequence bytes, trailing byte
   localparam int N_PAIRS     = 4;
   localparam int TOTAL_BYTES = 3*3 + 8*(2 + 3) + 8*2 + XFER_BYTES*(2*N_PAIRS + 8) + 16*3;
   localparam int WATCHDOG_NS = 2 * TOTAL_BYTES * `BYTE_W * 20 + 1000;

   logic                spi_clk;
   logic                spi_ss;
   logic                spi_mosi;
   logic                spi_miso;
   logic                ss_req;
   logic [`LED_W-1:0]   leds;
   integer              seed = 32'h8212;
   logic [`BYTE_W-1:0]  tx_seq [XFER_BYTES];
   logic [`BYTE_W-1:0]  rsp    [XFER_BYTES];
   logic [`WORD_W-1:0]  mem_model [`STORE_WORDS];
   logic [`ADDR_W-1:0]  addr_q [$];
   logic [7:0]          ctrl_model;

   tb_clk_gen clk0 (.ss_req, .spi_clk, .spi_ss);

   spi_mem_bridge dut0 (.spi_clk, .spi_ss, .spi_mosi, .spi_miso, .leds);

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic abort_run();
      $display("CHECKS FAILED");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task automatic check_byte(input string name, input logic [`BYTE_W-1:0] got, expected);
      if (got !== expected) begin
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, expected);
         abort_run();
      end
   endtask

   task automatic check_word(input string name, input logic [`WORD_W-1:0] got, expected);
      if (got !== expected) begin
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, expected);
         abort_run();
      end
   endtask

   task automatic check_leds(input string name, input logic [`LED_W-1:0] got, expected);
      if (got !== expected) begin
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, expected);
         abort_run();
      end
   endtask

   task automatic check_stat(input string name, input port_stat_t got, expected);
      if (got !== expected) begin
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, expected);
         abort_run();
      end
   endtask

   ////////////////////////////////////////////////////////////
   // SPI master
   ////////////////////////////////////////////////////////////

   // Entered right after a byte boundary edge
   task automatic spi_byte(input logic [`BYTE_W-1:0] tx, output logic [`BYTE_W-1:0] rx);
      for (int i = `BYTE_W-1; i >= 0; i--) begin
         spi_mosi <= tx[i];
         @(posedge spi_clk);
         rx[i] = spi_miso;                  // MISO moved on the falling edge
      end
   endtask

   task automatic run_transfer();
      for (int k = 0; k < XFER_BYTES; k++)
         spi_byte(tx_seq[k], rsp[k]);
   endtask

   task automatic pulse_select();
      ss_req <= 1'b1;
      @(posedge spi_clk);
      ss_req <= 1'b0;
      @(negedge spi_ss);                    // Released on a rising edge
   endtask

   task automatic expect_status_bit(input logic [4:0] idx, input logic expected);
      logic [`BYTE_W-1:0] rx;
      spi_byte(`CMD_READ_BIT, rx);
      spi_byte({3'b000, idx}, rx);
      spi_byte(`DUMMY_BYTE, rx);            // Reply arrives one byte late
      check_byte($sformatf("status bit %0d", idx), rx, {7'd0, expected});
   endtask

   task automatic write_ctrl_bit(input logic [3:0] idx, input logic val);
      logic [`BYTE_W-1:0] rx;
      spi_byte(`CMD_WRITE_BIT, rx);
      spi_byte({3'b000, idx, val}, rx);
   endtask

   // Reply loaded at mem_ctr k comes back in rsp[k+2]
   task automatic write_word(input logic [`ADDR_W-1:0] addr, input logic [`WORD_W-1:0] data);
      port_stat_t stat_empty;
      port_stat_t stat_one;
      stat_empty = '0;
      stat_one   = '{count: 6'd1, ovf_unf: 1'b0, error: 1'b0};
      tx_seq[0]  = `CMD_WRITE_MEM;
      for (int k = 0; k < 4; k++) begin
         tx_seq[1+k] = data[(3-k)*`BYTE_W +: `BYTE_W];
         tx_seq[5+k] = addr[(3-k)*`BYTE_W +: `BYTE_W];
      end
      tx_seq[9]  = `DUMMY_BYTE;
      tx_seq[10] = `DUMMY_BYTE;
      tx_seq[11] = 8'h00;
      run_transfer();
      for (int k = 0; k < 4; k++)
         check_byte($sformatf("write echo %0d", k), rsp[k+2], 8'(k));
      check_stat("wr status at push", port_stat_t'(rsp[6]), stat_empty);  // Before the push
      check_stat("wr status after push", port_stat_t'(rsp[7]), stat_one);
      check_byte("write echo 6", rsp[8], 8'd6);
      check_byte("write echo 7", rsp[9], 8'd7);
      check_byte("dummy at store", rsp[10], `DUMMY_BYTE);
      check_stat("wr status after store", port_stat_t'(rsp[11]), stat_empty);
      mem_model[addr[7:2]] = data;
      addr_q.push_back(addr);
   endtask

   task automatic read_word(input logic [`ADDR_W-1:0] addr);
      port_stat_t stat_one;
      stat_one  = '{count: 6'd1, ovf_unf: 1'b0, error: 1'b0};
      tx_seq[0] = `CMD_READ_MEM;
      for (int k = 0; k < 4; k++)
         tx_seq[1+k] = addr[(3-k)*`BYTE_W +: `BYTE_W];
      for (int k = 5; k < XFER_BYTES - 1; k++)
         tx_seq[k] = `DUMMY_BYTE;
      tx_seq[XFER_BYTES-1] = 8'h00;         // Carries out the last data byte
      run_transfer();
      check_byte("dummy at fetch", rsp[6], `DUMMY_BYTE);
      check_stat("rd status", port_stat_t'(rsp[7]), stat_one);
      check_word($sformatf("word at 0x%h", addr), {rsp[8], rsp[9], rsp[10], rsp[11]},
                 mem_model[addr[7:2]]);
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   task automatic test_reset_state();
      check_leds("leds", leds, 3'b111);
      expect_status_bit(5'd12, 1'b1);       // wr_empty
      expect_status_bit(5'd16, 1'b1);       // rd_empty
      expect_status_bit(5'd13, 1'b0);       // wr_full
   endtask

   task automatic test_ctrl_bits();
      ctrl_model = 8'($random(seed));
      for (int i = 0; i < 8; i++)
         write_ctrl_bit(4'(i), ctrl_model[i]);
      for (int i = 0; i < 8; i++)
         expect_status_bit(5'(i), ctrl_model[i]);
      check_leds("leds", leds, ~ctrl_model[2:0]);   // Last changed many bytes ago
   endtask

   task automatic test_read_back();
      for (int n = 0; n < N_PAIRS; n++)
         write_word($random(seed), $random(seed));
      foreach (addr_q[j])
         read_word(addr_q[j]);
   endtask

   // Each fetch is popped within its own sequence, so the buffer never builds up
   task automatic test_read_drain();
      repeat (5)
         read_word(addr_q[0]);
      expect_status_bit(5'd16, 1'b1);       // rd_empty
      expect_status_bit(5'd17, 1'b0);
      expect_status_bit(5'd18, 1'b0);       // rd_overflow
      expect_status_bit(5'd19, 1'b0);       // rd_error
   endtask

   task automatic test_select_reset();
      for (int i = 0; i < 8; i++)
         write_ctrl_bit(4'(i), 1'b1);
      check_leds("leds before select", leds, 3'b000);
      pulse_select();
      check_leds("leds after select", leds, 3'b111);
      for (int i = 0; i < 8; i++)
         expect_status_bit(5'(i), 1'b0);
      expect_status_bit(5'd15, 1'b0);       // wr_error
      expect_status_bit(5'd19, 1'b0);
      expect_status_bit(5'd12, 1'b1);
      read_word(addr_q[0]);                 // Store array keeps its contents
   endtask

   initial begin
      spi_mosi   = 1'b0;
      ss_req     = 1'b0;
      ctrl_model = '0;
      @(negedge spi_ss);
      test_reset_state();
      test_ctrl_bits();
      write_word($random(seed), $random(seed));
      test_read_back();
      test_read_drain();
      test_select_reset();
      $display("ALL CHECKS PASSED");
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      abort_run();
   end

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
   input  logic  ss_req,
   output logic  spi_clk,
   output logic  spi_ss
);

   logic [1:0]  ss_ctr;   // Cycles of select still to hold

   initial begin
      spi_clk = 1'b0;
      spi_ss  = 1'b1;
      ss_ctr  = 2'd2;
      forever #10 spi_clk = ~spi_clk;       // 20 ns period
   end

   // Select held high for two rising edges, released on an edge
   always @(posedge spi_clk) begin
      if (ss_req) begin
         spi_ss <= 1'b1;
         ss_ctr <= 2'd2;
      end else if (ss_ctr != 2'd0) begin
         ss_ctr <= ss_ctr - 2'd1;
         if (ss_ctr == 2'd1)
            spi_ss <= 1'b0;
      end
   end

endmodule

// ==== hw/spi_mem_bridge.sv ====
`timescale 1ns/1ps
`include "spi_bridge_defs.svh"

module spi_mem_bridge
   import spi_bridge_pkg::*;
(
   input  logic               spi_clk,
   input  logic               spi_ss,
   input  logic               spi_mosi,
   output logic               spi_miso,
   output logic [`LED_W-1:0]  leds
);

   logic                          byte_done;
   logic [`BYTE_W-1:0]            rx_byte;
   logic                          tx_load;
   logic [`BYTE_W-1:0]            tx_byte;
   mem_cmd_t                      mem_req;
   mem_stat_t                     mem_stat;
   logic                          bit_wr_en;
   logic [$clog2(`CTRL_W)-1:0]    bit_wr_idx;
   logic                          bit_wr_val;
   logic                          stat_bit;

   spi_byte_shifter shifter0 (
      .spi_clk, .spi_ss, .spi_mosi, .spi_miso,
      .byte_done, .rx_byte, .tx_load, .tx_byte
   );

   spi_cmd_fsm fsm0 (
      .spi_clk, .spi_ss, .byte_done, .rx_byte, .tx_load, .tx_byte,
      .mem_req, .mem_stat, .bit_wr_en, .bit_wr_idx, .bit_wr_val, .stat_bit
   );

   // Status bit address is the raw low bits of the byte after the command
   ctrl_status_regs regs0 (
      .spi_clk, .spi_ss, .bit_wr_en, .bit_wr_idx, .bit_wr_val,
      .bit_rd_idx (rx_byte[$clog2(`WORD_W)-1:0]),
      .mem_stat, .stat_bit, .leds
   );

   word_store store0 (.spi_clk, .spi_ss, .mem_req, .mem_stat);

endmodule

// ==== hw/word_store.sv ====
`timescale 1ns/1ps
`include "spi_bridge_defs.svh"

module word_store
   import spi_bridge_pkg::*;
(
   input  logic       spi_clk,
   input  logic       spi_ss,
   input  mem_cmd_t   mem_req,
   output mem_stat_t  mem_stat
);

   localparam int PTR_W = $clog2(`FIFO_DEPTH);
   localparam int IDX_W = $clog2(`STORE_WORDS);
   localparam logic [`FIFO_CNT_W-1:0] FULL_CNT = `FIFO_DEPTH;

   logic [`WORD_W-1:0]      mem [`STORE_WORDS];
   logic [`WORD_W-1:0]      wr_buf [`FIFO_DEPTH];
   logic [`WORD_W-1:0]      rd_buf [`FIFO_DEPTH];
   logic [PTR_W-1:0]        wr_head, wr_tail, rd_head, rd_tail;
   logic [`FIFO_CNT_W-1:0]  wr_count, rd_count;
   logic                    wr_underrun, wr_error, rd_overflow, rd_error;
   logic [IDX_W-1:0]        word_idx;
   logic                    wr_empty, wr_full, rd_empty, rd_full;
   logic                    wr_push, wr_pop, rd_push, rd_pop;

   assign word_idx = mem_req.byte_addr[IDX_W+1:2];    // Word aligned
   assign wr_empty = (wr_count == '0);
   assign wr_full  = (wr_count == FULL_CNT);
   assign rd_empty = (rd_count == '0);
   assign rd_full  = (rd_count == FULL_CNT);

   // Accepted moves, a blocked one only raises flags
   assign wr_push = mem_req.wr_en && !wr_full;
   assign wr_pop  = mem_req.cmd_en && mem_req.cmd_write && !wr_empty;
   assign rd_push = mem_req.cmd_en && !mem_req.cmd_write && !rd_full;
   assign rd_pop  = mem_req.rd_en && !rd_empty;

   always_ff @(posedge spi_clk) begin
      if (wr_pop)
         mem[word_idx] <= wr_buf[wr_head];
      if (wr_push)
         wr_buf[wr_tail] <= mem_req.wr_data;
      if (rd_push)
         rd_buf[rd_tail] <= mem[word_idx];
   end

   always_ff @(posedge spi_clk or posedge spi_ss) begin
      if (spi_ss) begin
         wr_head <= '0;
         wr_tail <= '0;
         rd_head <= '0;
         rd_tail <= '0;
         wr_count <= '0;
         rd_count <= '0;
         wr_underrun <= 1'b0;
         wr_error <= 1'b0;
         rd_overflow <= 1'b0;
         rd_error <= 1'b0;
      end else begin
         wr_tail  <= wr_tail + PTR_W'(wr_push);
         wr_head  <= wr_head + PTR_W'(wr_pop);
         rd_tail  <= rd_tail + PTR_W'(rd_push);
         rd_head  <= rd_head + PTR_W'(rd_pop);
         wr_count <= wr_count + `FIFO_CNT_W'(wr_push) - `FIFO_CNT_W'(wr_pop);
         rd_count <= rd_count + `FIFO_CNT_W'(rd_push) - `FIFO_CNT_W'(rd_pop);
         if (mem_req.cmd_en && mem_req.cmd_write && wr_empty) begin
            wr_underrun <= 1'b1;                      // Sticky until select
            wr_error    <= 1'b1;
         end
         if (mem_req.wr_en && wr_full)
            wr_error <= 1'b1;
         if (mem_req.cmd_en && !mem_req.cmd_write && rd_full) begin
            rd_overflow <= 1'b1;
            rd_error    <= 1'b1;
         end
         if (mem_req.rd_en && rd_empty)
            rd_error <= 1'b1;
      end
   end

   always_comb begin
      mem_stat.wr       = '{count: wr_count, ovf_unf: wr_underrun, error: wr_error};
      mem_stat.rd       = '{count: rd_count, ovf_unf: rd_overflow, error: rd_error};
      mem_stat.wr_empty = wr_empty;
      mem_stat.wr_full  = wr_full;
      mem_stat.rd_empty = rd_empty;
      mem_stat.rd_full  = rd_full;
      mem_stat.rd_data  = rd_buf[rd_head];
   end

   a_count_bound : assert property (@(posedge spi_clk) disable iff (spi_ss)
      wr_count <= FULL_CNT && rd_count <= FULL_CNT);

endmodule

// ==== hw/ctrl_status_regs.sv ====
`timescale 1ns/1ps
`include "spi_bridge_defs.svh"

module ctrl_status_regs
   import spi_bridge_pkg::*;
(
   input  logic                          spi_clk,
   input  logic                          spi_ss,
   input  logic                          bit_wr_en,
   input  logic [$clog2(`CTRL_W)-1:0]    bit_wr_idx,
   input  logic                          bit_wr_val,
   input  logic [$clog2(`WORD_W)-1:0]    bit_rd_idx,
   input  mem_stat_t                     mem_stat,
   output logic                          stat_bit,
   output logic [`LED_W-1:0]             leds
);

   logic [`CTRL_W-1:0]  ctrl_bits;
   status_word_u        status;

   always_ff @(posedge spi_clk or posedge spi_ss) begin
      if (spi_ss)
         ctrl_bits <= '0;
      else if (bit_wr_en)
         ctrl_bits[bit_wr_idx] <= bit_wr_val;
   end

   always_comb begin
      status                    = '0;                    // Reserved bits read 0
      status.fields.ctrl_echo   = ctrl_bits[`BYTE_W-1:0];
      status.fields.wr_empty    = mem_stat.wr_empty;
      status.fields.wr_full     = mem_stat.wr_full;
      status.fields.wr_underrun = mem_stat.wr.ovf_unf;
      status.fields.wr_error    = mem_stat.wr.error;
      status.fields.rd_empty    = mem_stat.rd_empty;
      status.fields.rd_full     = mem_stat.rd_full;
      status.fields.rd_overflow = mem_stat.rd.ovf_unf;
      status.fields.rd_error    = mem_stat.rd.error;
   end

   assign stat_bit = status.bits[bit_rd_idx];
   assign leds     = ~ctrl_bits[`LED_W-1:0];   // Active low leds

endmodule

// ==== hw/spi_cmd_fsm.sv ====
`timescale 1ns/1ps
`include "spi_bridge_defs.svh"

module spi_cmd_fsm
   import spi_bridge_pkg::*;
(
   input  logic                          spi_clk,
   input  logic                          spi_ss,
   input  logic                          byte_done,
   input  logic [`BYTE_W-1:0]            rx_byte,
   output logic                          tx_load,
   output logic [`BYTE_W-1:0]            tx_byte,
   output mem_cmd_t                      mem_req,
   input  mem_stat_t                     mem_stat,
   output logic                          bit_wr_en,
   output logic [$clog2(`CTRL_W)-1:0]    bit_wr_idx,
   output logic                          bit_wr_val,
   input  logic                          stat_bit
);

   typedef enum logic [2:0] {
      IDLE,
      READ_BIT,
      WRITE_BIT,
      READ_MEM,
      WRITE_MEM
   } fsm_state_t;

   fsm_state_t          state;
   logic [3:0]          mem_ctr;
   logic [1:0]          lane;      // Byte lane of the current address or data byte
   logic [`ADDR_W-1:0]  mem_addr;
   logic [`WORD_W-1:0]  wr_word;

   // Bytes arrive msb first, so counter 0 lands in the top lane
   assign lane = ~mem_ctr[1:0];

   ////////////////////////////////////////////////////////////
   // State and sequence counter
   ////////////////////////////////////////////////////////////

   always_ff @(posedge spi_clk or posedge spi_ss) begin
      if (spi_ss) begin
         state   <= IDLE;
         mem_ctr <= '0;
      end else if (byte_done) begin
         case (state)
            IDLE: begin
               mem_ctr <= '0;
               case (rx_byte)
                  `CMD_READ_BIT:  state <= READ_BIT;
                  `CMD_WRITE_BIT: state <= WRITE_BIT;
                  `CMD_READ_MEM:  state <= READ_MEM;
                  `CMD_WRITE_MEM: state <= WRITE_MEM;
                  default:        state <= IDLE;    // Unknown or trailing byte
               endcase
            end
            READ_BIT, WRITE_BIT: state <= IDLE;
            READ_MEM, WRITE_MEM: begin
               mem_ctr <= mem_ctr + 4'd1;
               if (mem_ctr == `MEM_XFER_LAST)
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Address and write word assembly
   always_ff @(posedge spi_clk) begin
      if (byte_done && state == WRITE_MEM) begin
         if (mem_ctr < 4'd4)
            wr_word[lane*`BYTE_W +: `BYTE_W] <= rx_byte;   // Data first
         else if (mem_ctr < 4'd8)
            mem_addr[lane*`BYTE_W +: `BYTE_W] <= rx_byte;  // Then address
      end
      if (byte_done && state == READ_MEM && mem_ctr < 4'd4)
         mem_addr[lane*`BYTE_W +: `BYTE_W] <= rx_byte;
   end

   ////////////////////////////////////////////////////////////
   // Strobes to the store and the control register
   ////////////////////////////////////////////////////////////

   always_comb begin
      mem_req.cmd_write = (state == WRITE_MEM);
      mem_req.cmd_en    = byte_done &&
                          ((state == READ_MEM  && mem_ctr == 4'd4) ||
                           (state == WRITE_MEM && mem_ctr == 4'd8));
      mem_req.wr_en     = byte_done && state == WRITE_MEM && mem_ctr == 4'd4;
      mem_req.rd_en     = byte_done && state == READ_MEM && mem_ctr == `MEM_XFER_LAST;
      mem_req.byte_addr = mem_addr;
      mem_req.wr_data   = wr_word;
   end

   assign bit_wr_en  = byte_done && (state == WRITE_BIT);
   assign bit_wr_idx = rx_byte[4:1];
   assign bit_wr_val = rx_byte[0];

   ////////////////////////////////////////////////////////////
   // Reply bytes, shifted out during the next transfer
   ////////////////////////////////////////////////////////////

   always_comb begin
      tx_load = 1'b0;
      tx_byte = '0;
      if (byte_done) begin
         case (state)
            READ_BIT: begin
               tx_load = 1'b1;
               tx_byte = {{(`BYTE_W-1){1'b0}}, stat_bit};
            end
            READ_MEM: begin
               tx_load = (mem_ctr >= 4'd4);   // Nothing useful during the address
               case (mem_ctr)
                  4'd4:    tx_byte = `DUMMY_BYTE;            // Read issued here
                  4'd5:    tx_byte = mem_stat.rd;
                  4'd6:    tx_byte = mem_stat.rd_data[31:24];
                  4'd7:    tx_byte = mem_stat.rd_data[23:16];
                  4'd8:    tx_byte = mem_stat.rd_data[15:8];
                  4'd9:    tx_byte = mem_stat.rd_data[7:0];  // Popped on this edge
                  default: tx_byte = '0;
               endcase
            end
            WRITE_MEM: begin
               tx_load = 1'b1;
               case (mem_ctr)
                  4'd4, 4'd5, 4'd9: tx_byte = mem_stat.wr;
                  4'd8:             tx_byte = `DUMMY_BYTE;
                  default:          tx_byte = {{(`BYTE_W-4){1'b0}}, mem_ctr}; // Echo
               endcase
            end
            default: begin
               tx_load = 1'b0;
               tx_byte = '0;
            end
         endcase
      end
   end

   // Write data and the store command never share a byte boundary
   a_cmd_wr_excl : assert property (@(posedge spi_clk) disable iff (spi_ss)
      !(mem_req.cmd_en && mem_req.wr_en));

endmodule

// ==== hw/spi_byte_shifter.sv ====
`timescale 1ns/1ps
`include "spi_bridge_defs.svh"

module spi_byte_shifter (
   input  logic                spi_clk,
   input  logic                spi_ss,
   input  logic                spi_mosi,
   output logic                spi_miso,
   output logic                byte_done,
   output logic [`BYTE_W-1:0]  rx_byte,
   input  logic                tx_load,
   input  logic [`BYTE_W-1:0]  tx_byte
);

   logic [2:0]          bit_ctr;
   logic [`BYTE_W-1:0]  rx_shift;
   logic [`BYTE_W-1:0]  tx_shift;

   // Last bit of the byte arrives this edge
   assign byte_done = (bit_ctr == 3'd7);
   assign rx_byte   = {rx_shift[`BYTE_W-2:0], spi_mosi};

   always_ff @(posedge spi_clk or posedge spi_ss) begin
      if (spi_ss) begin
         bit_ctr  <= '0;
         tx_shift <= '0;
      end else begin
         bit_ctr <= bit_ctr + 3'd1;
         if (tx_load)
            tx_shift <= tx_byte;                             // Goes out next byte
         else
            tx_shift <= {tx_shift[`BYTE_W-2:0], 1'b0};
      end
   end

   always_ff @(posedge spi_clk) begin
      rx_shift <= rx_byte;
   end

   // MISO changes on the falling edge, master samples on the rising one
   always_ff @(negedge spi_clk or posedge spi_ss) begin
      if (spi_ss)
         spi_miso <= 1'b0;
      else
         spi_miso <= tx_shift[`BYTE_W-1];
   end

   // A fresh select always starts on a byte boundary
   a_no_early_byte : assert property (@(posedge spi_clk)
      $fell(spi_ss) |-> !byte_done [*7]);

endmodule

// ==== hw/spi_bridge_pkg.sv ====
`include "spi_bridge_defs.svh"

package spi_bridge_pkg;

   // Request from the command FSM to the word store
   typedef struct packed {
      logic                 cmd_en;
      logic                 cmd_write;   // 1 = store write buffer head, 0 = fetch word
      logic                 rd_en;
      logic                 wr_en;
      logic [`ADDR_W-1:0]   byte_addr;
      logic [`WORD_W-1:0]   wr_data;
   } mem_cmd_t;

   // One buffer as seen over SPI, exactly one byte
   typedef struct packed {
      logic [`FIFO_CNT_W-1:0] count;
      logic                   ovf_unf;   // Underrun on wr side, overflow on rd side
      logic                   error;
   } port_stat_t;

   typedef struct packed {
      port_stat_t           wr;
      port_stat_t           rd;
      logic                 wr_empty;
      logic                 wr_full;
      logic                 rd_empty;
      logic                 rd_full;
      logic [`WORD_W-1:0]   rd_data;     // Head of the read buffer
   } mem_stat_t;

   // Status word layout, msb first
   typedef struct packed {
      logic [11:0]          reserved_hi;
      logic                 rd_error;
      logic                 rd_overflow;
      logic                 rd_full;
      logic                 rd_empty;
      logic                 wr_error;
      logic                 wr_underrun;
      logic                 wr_full;
      logic                 wr_empty;
      logic [3:0]           reserved_lo;  // Old calib and cmd fifo bits
      logic [`BYTE_W-1:0]   ctrl_echo;
   } status_fields_t;

   // Filled by field name, read back by SPI bit address
   typedef union packed {
      logic [`WORD_W-1:0]   bits;
      status_fields_t       fields;
   } status_word_u;

endpackage

// ==== include/spi_bridge_defs.svh ====
`ifndef SPI_BRIDGE_DEFS_SVH
`define SPI_BRIDGE_DEFS_SVH

// Command codes, first byte of every transfer
`define CMD_READ_BIT   8'h01
`define CMD_WRITE_BIT  8'h02
`define CMD_READ_MEM   8'h03
`define CMD_WRITE_MEM  8'h04

// Data path widths
`define BYTE_W         8
`define WORD_W         32
`define CTRL_W         16
`define LED_W          3
`define ADDR_W         32

// Buffer sizing in word_store
`define FIFO_CNT_W     6
`define FIFO_DEPTH     4
`define STORE_WORDS    64   // Indexed by byte address bits 7:2

// Filler byte sent back while a memory command is issued
`define DUMMY_BYTE     8'hAA

// Memory sequences run mem_ctr 0..9
`define MEM_XFER_LAST  4'd9

`endif
